// File: hw/frontend_defs.svh
// Front end configuration macros
// Reset fetch address and the depths of the fetch target queue
// and the instruction buffer

`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// First fetch address after reset
`define FRONTEND_RESET_PC 32'h0000_1000

// Fetch target queue entries
`define FTQ_DEPTH 4

// Instruction buffer entries
`define IBUF_DEPTH 8

`endif

// File: hw/frontend_pkg.sv
// Front end shared types
// Address, instruction and register index types, opcode values,
// decoded instruction classes and bus owner encoding

package frontend_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // Major opcodes, bits 6..0 of the instruction
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    CLASS_ALU, CLASS_ALU_IMM, CLASS_LOAD, CLASS_STORE, CLASS_BRANCH,
    CLASS_JUMP, CLASS_UPPER_IMM, CLASS_SYSTEM, CLASS_ILLEGAL
  } inst_class_e;

  typedef enum logic {OWNER_FETCH, OWNER_DATA} arb_owner_e;

endpackage

// File: hw/mem_bus_if.sv
// Request/grant read bus
// The master holds req and addr until gnt, then exactly one rvalid
// with rdata follows one or more cycles later

interface mem_bus_if import frontend_pkg::*; ();

  logic  req;
  addr_t addr;
  logic  gnt;
  logic  rvalid;
  inst_t rdata;

  modport master (
    output req, addr,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, addr,
    output gnt, rvalid, rdata
  );

endinterface

// File: hw/fetch_target_queue.sv
// Fetch target queue
// Generates sequential fetch addresses and buffers them in a small
// FIFO. A redirect restarts the stream at the redirect target

`include "frontend_defs.svh"

module fetch_target_queue import frontend_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  redirect_i,
  input  addr_t redirect_pc_i,
  input  logic  pop_i,
  output logic  valid_o,
  output addr_t addr_o
);

  localparam int PTR_W = $clog2(`FTQ_DEPTH);
  localparam int CNT_W = $clog2(`FTQ_DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`FTQ_DEPTH);

  addr_t            mem_q [`FTQ_DEPTH];
  addr_t            next_pc_q;
  logic [PTR_W-1:0] rptr_q;
  logic [PTR_W-1:0] wptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Generate whenever there is room
  assign do_push = (count_q != FULL_CNT);
  assign do_pop  = pop_i && (count_q != '0);

  assign valid_o = (count_q != '0);
  assign addr_o  = mem_q[rptr_q];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      next_pc_q <= `FRONTEND_RESET_PC;
      rptr_q    <= '0;
      wptr_q    <= '0;
      count_q   <= '0;
    end else if (redirect_i) begin
      // Queue restarts holding only the target
      next_pc_q <= redirect_pc_i + 32'd4;
      rptr_q    <= '0;
      wptr_q    <= PTR_W'(1);
      count_q   <= CNT_W'(1);
    end else begin
      if (do_push) begin
        next_pc_q <= next_pc_q + 32'd4;
        wptr_q    <= wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Address storage
  always_ff @(posedge clk) begin
    if (redirect_i) begin
      mem_q[0] <= redirect_pc_i;
    end else if (do_push) begin
      mem_q[wptr_q] <= next_pc_q;
    end
  end

endmodule

// File: hw/fetch_unit.sv
// Instruction fetch unit
// Pops one fetch address at a time, reads the word over the bus and
// pushes it with its pc into the instruction buffer

module fetch_unit import frontend_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  redirect_i,
  input  logic  ftq_valid_i,
  input  addr_t ftq_addr_i,
  output logic  ftq_pop_o,
  input  logic  ibuf_almost_full_i,
  output logic  push_o,
  output addr_t push_pc_o,
  output inst_t push_inst_o,
  mem_bus_if.master bus
);

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_WAIT} fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic         stale_q;
  logic         stale_d;
  addr_t        addr_q;
  logic         resp_done;

  // Never pop in a redirect cycle, the popped entry would be old stream
  assign ftq_pop_o = (state_q == FETCH_IDLE) && ftq_valid_i && !ibuf_almost_full_i &&
                     !redirect_i;

  assign bus.req  = (state_q == FETCH_REQ);
  assign bus.addr = addr_q;

  assign resp_done   = (state_q == FETCH_WAIT) && bus.rvalid;
  assign push_o      = resp_done && !stale_q && !redirect_i;
  assign push_pc_o   = addr_q;
  assign push_inst_o = bus.rdata;

  always_comb begin
    state_d = state_q;
    stale_d = stale_q;
    unique case (state_q)
      FETCH_IDLE: if (ftq_pop_o) state_d = FETCH_REQ;
      FETCH_REQ:  if (bus.gnt) state_d = FETCH_WAIT;
      FETCH_WAIT: if (bus.rvalid) state_d = FETCH_IDLE;
      default:    state_d = FETCH_IDLE;
    endcase
    // Mark the read in flight as belonging to the old stream
    if (resp_done) begin
      stale_d = 1'b0;
    end else if (redirect_i && (state_q != FETCH_IDLE)) begin
      stale_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= FETCH_IDLE;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      stale_q <= stale_d;
    end
  end

  always_ff @(posedge clk) begin
    if (ftq_pop_o) addr_q <= ftq_addr_i;
  end

endmodule

// File: hw/mem_arbiter.sv
// Memory bus arbiter
// Round robin between the fetch bus and the data read port, one
// transaction outstanding, responses steered back to their owner

module mem_arbiter import frontend_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  mem_bus_if.slave  fetch_bus,
  input  logic  data_req_i,
  input  addr_t data_addr_i,
  output logic  data_gnt_o,
  output logic  data_rvalid_o,
  output inst_t data_rdata_o,
  mem_bus_if.master mem_bus
);

  arb_owner_e last_q;
  arb_owner_e owner_q;
  arb_owner_e sel;
  logic       busy_q;
  logic       hold_q;
  logic       can_issue;
  logic       granted;

  // Bus free, or freed by this cycle's response
  assign can_issue = !busy_q || mem_bus.rvalid;

  always_comb begin
    if (hold_q) begin
      // Keep the presented master until it is granted
      sel = owner_q;
    end else if (fetch_bus.req && data_req_i) begin
      sel = (last_q == OWNER_FETCH) ? OWNER_DATA : OWNER_FETCH;
    end else if (data_req_i) begin
      sel = OWNER_DATA;
    end else begin
      sel = OWNER_FETCH;
    end
  end

  assign mem_bus.req  = can_issue && (fetch_bus.req || data_req_i);
  assign mem_bus.addr = (sel == OWNER_DATA) ? data_addr_i : fetch_bus.addr;
  assign granted      = mem_bus.req && mem_bus.gnt;

  assign fetch_bus.gnt = granted && (sel == OWNER_FETCH);
  assign data_gnt_o    = granted && (sel == OWNER_DATA);

  // Response routing by recorded owner
  assign fetch_bus.rvalid = mem_bus.rvalid && busy_q && (owner_q == OWNER_FETCH);
  assign data_rvalid_o    = mem_bus.rvalid && busy_q && (owner_q == OWNER_DATA);
  assign fetch_bus.rdata  = mem_bus.rdata;
  assign data_rdata_o     = mem_bus.rdata;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      last_q  <= OWNER_DATA;
      owner_q <= OWNER_FETCH;
      busy_q  <= 1'b0;
      hold_q  <= 1'b0;
    end else begin
      if (mem_bus.req) owner_q <= sel;
      hold_q <= mem_bus.req && !mem_bus.gnt;
      if (granted) begin
        busy_q <= 1'b1;
        last_q <= sel;
      end else if (mem_bus.rvalid) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

// File: hw/inst_buffer.sv
// Instruction buffer
// Circular FIFO of pc and instruction pairs between fetch and decode,
// with an almost-full level and flush

`include "frontend_defs.svh"

module inst_buffer import frontend_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  flush_i,
  input  logic  push_i,
  input  addr_t push_pc_i,
  input  inst_t push_inst_i,
  output logic  almost_full_o,
  input  logic  pop_i,
  output logic  head_valid_o,
  output addr_t head_pc_o,
  output inst_t head_inst_o
);

  localparam int PTR_W = $clog2(`IBUF_DEPTH);
  localparam int CNT_W = $clog2(`IBUF_DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`IBUF_DEPTH);

  addr_t            pc_mem_q   [`IBUF_DEPTH];
  inst_t            inst_mem_q [`IBUF_DEPTH];
  logic [PTR_W-1:0] rptr_q;
  logic [PTR_W-1:0] wptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && (count_q != FULL_CNT);
  assign do_pop  = pop_i && (count_q != '0);

  // At most one free slot left
  assign almost_full_o = (count_q >= FULL_CNT - 1'b1);
  assign head_valid_o  = (count_q != '0);
  assign head_pc_o     = pc_mem_q[rptr_q];
  assign head_inst_o   = inst_mem_q[rptr_q];

  always_ff @(posedge clk) begin
    if (!rst_n_i || flush_i) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) wptr_q <= wptr_q + 1'b1;
      if (do_pop)  rptr_q <= rptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      pc_mem_q[wptr_q]   <= push_pc_i;
      inst_mem_q[wptr_q] <= push_inst_i;
    end
  end

endmodule

// File: hw/decode_stage.sv
// Decode stage
// Classifies the instruction at the buffer head by opcode and holds
// it with pc and rd in a pipeline register for the back end

module decode_stage import frontend_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        flush_i,
  input  logic        head_valid_i,
  input  addr_t       head_pc_i,
  input  inst_t       head_inst_i,
  output logic        pop_o,
  input  logic        dec_ready_i,
  output logic        dec_valid_o,
  output addr_t       dec_pc_o,
  output inst_t       dec_inst_o,
  output inst_class_e dec_class_o,
  output reg_idx_t    dec_rd_o
);

  inst_class_e cls;

  always_comb begin
    unique case (opcode_t'(head_inst_i[6:0]))
      OPC_OP:              cls = CLASS_ALU;
      OPC_OP_IMM:          cls = CLASS_ALU_IMM;
      OPC_LOAD:            cls = CLASS_LOAD;
      OPC_STORE:           cls = CLASS_STORE;
      OPC_BRANCH:          cls = CLASS_BRANCH;
      OPC_JAL, OPC_JALR:   cls = CLASS_JUMP;
      OPC_LUI, OPC_AUIPC:  cls = CLASS_UPPER_IMM;
      OPC_SYSTEM:          cls = CLASS_SYSTEM;
      default:             cls = CLASS_ILLEGAL;
    endcase
  end

  // Load when the register is empty or drained this cycle
  assign pop_o = head_valid_i && (!dec_valid_o || dec_ready_i) && !flush_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i || flush_i) begin
      dec_valid_o <= 1'b0;
    end else if (pop_o) begin
      dec_valid_o <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (pop_o) begin
      dec_pc_o    <= head_pc_i;
      dec_inst_o  <= head_inst_i;
      dec_class_o <= cls;
      dec_rd_o    <= head_inst_i[11:7];
    end
  end

endmodule

// File: hw/frontend_top.sv
// Front end top level
// Fetch target queue, fetch unit, memory arbiter, instruction buffer
// and decode stage, with the memory bus and data port as plain ports

module frontend_top import frontend_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        redirect_i,
  input  addr_t       redirect_pc_i,
  output logic        mem_req_o,
  output addr_t       mem_addr_o,
  input  logic        mem_gnt_i,
  input  logic        mem_rvalid_i,
  input  inst_t       mem_rdata_i,
  input  logic        data_req_i,
  input  addr_t       data_addr_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output inst_t       data_rdata_o,
  input  logic        dec_ready_i,
  output logic        dec_valid_o,
  output addr_t       dec_pc_o,
  output inst_t       dec_inst_o,
  output inst_class_e dec_class_o,
  output reg_idx_t    dec_rd_o
);

  logic  ftq_valid;
  addr_t ftq_addr;
  logic  ftq_pop;
  logic  push;
  addr_t push_pc;
  inst_t push_inst;
  logic  ibuf_almost_full;
  logic  head_valid;
  addr_t head_pc;
  inst_t head_inst;
  logic  head_pop;

  mem_bus_if fetch_bus ();
  mem_bus_if mem_bus ();

  // ====================================================================
  // Memory port breakout
  // ====================================================================
  assign mem_req_o      = mem_bus.req;
  assign mem_addr_o     = mem_bus.addr;
  assign mem_bus.gnt    = mem_gnt_i;
  assign mem_bus.rvalid = mem_rvalid_i;
  assign mem_bus.rdata  = mem_rdata_i;

  // ====================================================================
  // Fetch path
  // ====================================================================
  fetch_target_queue u_ftq (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pop_i         (ftq_pop),
    .valid_o       (ftq_valid),
    .addr_o        (ftq_addr)
  );

  fetch_unit u_fetch (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .redirect_i         (redirect_i),
    .ftq_valid_i        (ftq_valid),
    .ftq_addr_i         (ftq_addr),
    .ftq_pop_o          (ftq_pop),
    .ibuf_almost_full_i (ibuf_almost_full),
    .push_o             (push),
    .push_pc_o          (push_pc),
    .push_inst_o        (push_inst),
    .bus                (fetch_bus)
  );

  mem_arbiter u_arb (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .fetch_bus     (fetch_bus),
    .data_req_i    (data_req_i),
    .data_addr_i   (data_addr_i),
    .data_gnt_o    (data_gnt_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .mem_bus       (mem_bus)
  );

  // ====================================================================
  // Buffer and decode
  // ====================================================================
  inst_buffer u_ibuf (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (redirect_i),
    .push_i        (push),
    .push_pc_i     (push_pc),
    .push_inst_i   (push_inst),
    .almost_full_o (ibuf_almost_full),
    .pop_i         (head_pop),
    .head_valid_o  (head_valid),
    .head_pc_o     (head_pc),
    .head_inst_o   (head_inst)
  );

  decode_stage u_dec (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (redirect_i),
    .head_valid_i (head_valid),
    .head_pc_i    (head_pc),
    .head_inst_i  (head_inst),
    .pop_o        (head_pop),
    .dec_ready_i  (dec_ready_i),
    .dec_valid_o  (dec_valid_o),
    .dec_pc_o     (dec_pc_o),
    .dec_inst_o   (dec_inst_o),
    .dec_class_o  (dec_class_o),
    .dec_rd_o     (dec_rd_o)
  );

endmodule

// File: tb/tb_frontend.sv
// Front end testbench
// Directed tests with a memory model on the shared bus, a reference
// model for the decoded class and rd, and a cycle-count timeout

`include "frontend_defs.svh"

module tb_frontend import frontend_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // About 200 decoded outputs at a few cycles each plus wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        rst_n_i;
  logic        redirect_i;
  addr_t       redirect_pc_i;
  logic        mem_req_o;
  addr_t       mem_addr_o;
  logic        mem_gnt_i;
  logic        mem_rvalid_i;
  inst_t       mem_rdata_i;
  logic        data_req_i;
  addr_t       data_addr_i;
  logic        data_gnt_o;
  logic        data_rvalid_o;
  inst_t       data_rdata_o;
  logic        dec_ready_i;
  logic        dec_valid_o;
  addr_t       dec_pc_o;
  inst_t       dec_inst_o;
  inst_class_e dec_class_o;
  reg_idx_t    dec_rd_o;

  int          cycle_cnt;
  int          data_rvalid_cnt;
  addr_t       stream_pc;

  frontend_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==================================================================
  // Reference model
  // ==================================================================
  function automatic logic [6:0] table_opcode(logic [2:0] idx);
    case (idx)
      3'd0:    return 7'b0110011;
      3'd1:    return 7'b0010011;
      3'd2:    return 7'b0000011;
      3'd3:    return 7'b0100011;
      3'd4:    return 7'b1100011;
      3'd5:    return 7'b1101111;
      3'd6:    return 7'b0110111;
      default: return 7'b1111111;  // illegal
    endcase
  endfunction

  // Opcode picked by address bits 4..2 with address bits above it
  function automatic inst_t mem_word(addr_t addr);
    return {addr[26:2], table_opcode(addr[4:2])};
  endfunction

  function automatic inst_class_e exp_class(inst_t inst);
    case (inst[6:0])
      7'b0110011:             return CLASS_ALU;
      7'b0010011:             return CLASS_ALU_IMM;
      7'b0000011:             return CLASS_LOAD;
      7'b0100011:             return CLASS_STORE;
      7'b1100011:             return CLASS_BRANCH;
      7'b1101111, 7'b1100111: return CLASS_JUMP;
      7'b0110111, 7'b0010111: return CLASS_UPPER_IMM;
      7'b1110011:             return CLASS_SYSTEM;
      default:                return CLASS_ILLEGAL;
    endcase
  endfunction

  // ==================================================================
  // Checks
  // ==================================================================
  task automatic report_error(string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_inst(string name, inst_t got, inst_t exp);
    if (got !== exp) report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_class(string name, inst_class_e got, inst_class_e exp);
    if (got !== exp) report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_rd(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) report_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_error("Timeout: the tests did not finish within the cycle limit");
    end
  end

  always @(negedge clk) begin
    if (data_rvalid_o === 1'b1) data_rvalid_cnt++;
  end

  // ==================================================================
  // Memory model with grant after 0..2 cycles and response after 1..3
  // ==================================================================
  initial begin : memory_model
    logic  req_s;
    logic  gnt_s;
    addr_t addr_s;
    logic  pend;
    addr_t pend_addr;
    int    resp_cnt;
    int    gnt_cnt;
    pend      = 1'b0;
    pend_addr = '0;
    resp_cnt  = 0;
    gnt_cnt   = 0;
    forever begin
      @(negedge clk);
      req_s  = mem_req_o;
      gnt_s  = mem_gnt_i;
      addr_s = mem_addr_o;
      @(posedge clk);
      mem_rvalid_i <= 1'b0;
      if (pend) begin
        if (resp_cnt == 0) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= mem_word(pend_addr);
          pend = 1'b0;
        end else begin
          resp_cnt--;
        end
      end
      // A request granted at this edge
      if (req_s === 1'b1 && gnt_s === 1'b1) begin
        pend      = 1'b1;
        pend_addr = addr_s;
        resp_cnt  = $urandom_range(0, 2);
        gnt_cnt   = $urandom_range(0, 2);
      end else if (req_s === 1'b1 && gnt_cnt > 0) begin
        gnt_cnt--;
      end
      mem_gnt_i <= (gnt_cnt == 0);
    end
  end

  // ==================================================================
  // Drivers
  // ==================================================================

  // Accept n decoded outputs with consecutive pcs from stream_pc
  task automatic take_decoded(int n, int stall_pct);
    int       got;
    logic     held;
    addr_t    held_pc;
    inst_t    held_inst;
    inst_t    word;
    got  = 0;
    held = 1'b0;
    while (got < n) begin
      @(posedge clk);
      dec_ready_i <= ($urandom_range(0, 99) >= stall_pct);
      @(negedge clk);
      if (held) begin
        if (dec_valid_o !== 1'b1) report_error("Decoded output dropped while stalled");
        check_addr("dec_pc_o", dec_pc_o, held_pc);
        check_inst("dec_inst_o", dec_inst_o, held_inst);
      end
      held = 1'b0;
      if (dec_valid_o === 1'b1) begin
        word = mem_word(stream_pc);
        check_addr("dec_pc_o", dec_pc_o, stream_pc);
        check_inst("dec_inst_o", dec_inst_o, word);
        check_class("dec_class_o", dec_class_o, exp_class(word));
        check_rd("dec_rd_o", dec_rd_o, word[11:7]);
        if (dec_ready_i) begin
          stream_pc = stream_pc + 32'd4;
          got++;
        end else begin
          held      = 1'b1;
          held_pc   = dec_pc_o;
          held_inst = dec_inst_o;
        end
      end
    end
    // Stop consuming so nothing is taken unchecked
    @(posedge clk);
    dec_ready_i <= 1'b0;
  endtask

  task automatic redirect_to(addr_t target, int n);
    @(posedge clk);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    @(posedge clk);
    redirect_i <= 1'b0;
    stream_pc = target;
    take_decoded(n, 0);
  endtask

  task automatic data_read(addr_t addr);
    @(posedge clk);
    data_req_i  <= 1'b1;
    data_addr_i <= addr;
    do @(negedge clk); while (data_gnt_o !== 1'b1);
    @(posedge clk);
    data_req_i <= 1'b0;
    do @(negedge clk); while (data_rvalid_o !== 1'b1);
    check_inst("data_rdata_o", data_rdata_o, mem_word(addr));
  endtask

  // ==================================================================
  // Tests
  // ==================================================================
  task automatic reset_stream();
    stream_pc = `FRONTEND_RESET_PC;
    take_decoded(40, 0);
  endtask

  task automatic stall_hold();
    take_decoded(60, 40);
  endtask

  task automatic redirect_in_flight();
    take_decoded(5, 0);
    redirect_to(32'h0000_2a4c, 21);
  endtask

  task automatic data_port_reads();
    int reads;
    reads = 10;
    data_rvalid_cnt = 0;
    fork
      take_decoded(40, 0);
      begin
        for (int i = 0; i < reads; i++) begin
          data_read(32'h0000_8000 + (addr_t'($urandom_range(0, 255)) << 2));
          repeat ($urandom_range(0, 3)) @(posedge clk);
        end
      end
    join
    repeat (5) @(posedge clk);
    if (data_rvalid_cnt != reads) begin
      report_error($sformatf("Data port gave %0d responses for %0d reads",
                             data_rvalid_cnt, reads));
    end
  endtask

  // One target per opcode table entry
  task automatic class_sweep();
    for (int k = 0; k < 8; k++) begin
      redirect_to(32'h0001_0000 + 32'(k) * 32'h100 + 32'(k) * 4, 3);
    end
  endtask

  initial begin
    void'($urandom(32'hba639cff));
    cycle_cnt     = 0;
    rst_n_i       <= 1'b0;
    redirect_i    <= 1'b0;
    redirect_pc_i <= '0;
    mem_gnt_i     <= 1'b0;
    mem_rvalid_i  <= 1'b0;
    mem_rdata_i   <= '0;
    data_req_i    <= 1'b0;
    data_addr_i   <= '0;
    dec_ready_i   <= 1'b1;
    repeat (9) @(posedge clk);
    @(negedge clk);
    if (mem_req_o !== 1'b0 || data_gnt_o !== 1'b0 || data_rvalid_o !== 1'b0 ||
        dec_valid_o !== 1'b0) begin
      report_error("Bus request, data port or decode output not low in reset");
    end
    @(posedge clk);
    rst_n_i <= 1'b1;

    reset_stream();
    stall_hold();
    redirect_in_flight();
    data_port_reads();
    class_sweep();

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hw
hw/frontend_pkg.sv
hw/mem_bus_if.sv
hw/fetch_target_queue.sv
hw/fetch_unit.sv
hw/mem_arbiter.sv
hw/inst_buffer.sv
hw/decode_stage.sv
hw/frontend_top.sv
tb/tb_frontend.sv

// File: Bender.yml
package:
  name: frontend

sources:
  - include_dirs:
      - hw
    files:
      - hw/frontend_pkg.sv
      - hw/mem_bus_if.sv
      - hw/fetch_target_queue.sv
      - hw/fetch_unit.sv
      - hw/mem_arbiter.sv
      - hw/inst_buffer.sv
      - hw/decode_stage.sv
      - hw/frontend_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_frontend.sv
